//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opc_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  localparam opc_t OPC_LUI     = 7'b0110111;
  localparam opc_t OPC_AUIPC   = 7'b0010111;
  localparam opc_t OPC_JAL     = 7'b1101111;
  localparam opc_t OPC_JALR    = 7'b1100111;
  localparam opc_t OPC_BRANCH  = 7'b1100011;
  localparam opc_t OPC_LOAD    = 7'b0000011;
  localparam opc_t OPC_STORE   = 7'b0100011;
  localparam opc_t OPC_OPIMM   = 7'b0010011;
  localparam opc_t OPC_OP      = 7'b0110011;
  localparam opc_t OPC_OPIMM32 = 7'b0011011;
  localparam opc_t OPC_OP32    = 7'b0111011;
  localparam opc_t OPC_SYSTEM  = 7'b1110011;

  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

  // funct3 values that change how funct7 is checked.
  localparam funct3_t F3_ADD = 3'b000;
  localparam funct3_t F3_SLL = 3'b001;
  localparam funct3_t F3_SR  = 3'b101;

  localparam funct7_t F7_BASE = 7'b000_0000;
  localparam funct7_t F7_ALT  = 7'b010_0000; // SUB and SRA.

  function automatic opc_t opc_of(input instr_t instr);
    return instr[6:0];
  endfunction

  function automatic reg_idx_t rd_of(input instr_t instr);
    return instr[11:7];
  endfunction

  function automatic reg_idx_t rs1_of(input instr_t instr);
    return instr[19:15];
  endfunction

  function automatic reg_idx_t rs2_of(input instr_t instr);
    return instr[24:20];
  endfunction

  function automatic funct3_t funct3_of(input instr_t instr);
    return instr[14:12];
  endfunction

  function automatic funct7_t funct7_of(input instr_t instr);
    return instr[31:25];
  endfunction

endpackage

//--- design/idu_ctrl_pkg.sv
package idu_ctrl_pkg;

  typedef logic [4:0] alu_op_t;
  typedef logic [2:0] br_op_t;
  typedef logic [2:0] ld_op_t;
  typedef logic [3:0] st_len_t;
  typedef logic [2:0] wb_sel_t;

  localparam alu_op_t ALU_ADD    = 5'd0;
  localparam alu_op_t ALU_SUB    = 5'd1;
  localparam alu_op_t ALU_SLL    = 5'd2;
  localparam alu_op_t ALU_SLT    = 5'd3;
  localparam alu_op_t ALU_SLTU   = 5'd4;
  localparam alu_op_t ALU_XOR    = 5'd5;
  localparam alu_op_t ALU_SRL    = 5'd6;
  localparam alu_op_t ALU_SRA    = 5'd7;
  localparam alu_op_t ALU_OR     = 5'd8;
  localparam alu_op_t ALU_AND    = 5'd9;
  localparam alu_op_t ALU_PASS_B = 5'd10; // Second operand straight through.

  localparam br_op_t BR_BEQ  = 3'b000;
  localparam br_op_t BR_BNE  = 3'b001;
  localparam br_op_t BR_BLT  = 3'b100;
  localparam br_op_t BR_BGE  = 3'b101;
  localparam br_op_t BR_BLTU = 3'b110;
  localparam br_op_t BR_BGEU = 3'b111;

  localparam ld_op_t LD_LB  = 3'b000;
  localparam ld_op_t LD_LH  = 3'b001;
  localparam ld_op_t LD_LW  = 3'b010;
  localparam ld_op_t LD_LD  = 3'b011;
  localparam ld_op_t LD_LBU = 3'b100;
  localparam ld_op_t LD_LHU = 3'b101;
  localparam ld_op_t LD_LWU = 3'b110;

  localparam st_len_t ST_LEN_B = 4'd1;
  localparam st_len_t ST_LEN_H = 4'd2;
  localparam st_len_t ST_LEN_W = 4'd4;
  localparam st_len_t ST_LEN_D = 4'd8;

  localparam wb_sel_t WB_ALU  = 3'd0;
  localparam wb_sel_t WB_LOAD = 3'd1;
  localparam wb_sel_t WB_PC4  = 3'd2;

endpackage

//--- design/decode_ctrl_if.sv
`timescale 1ns/1ps

interface decode_ctrl_if;
  logic                  branch_en;
  idu_ctrl_pkg::br_op_t  branch_op;
  logic                  alu_en;
  logic                  alu_pc_en;
  logic                  alu_imm_en;
  idu_ctrl_pkg::alu_op_t alu_op;
  logic                  alu_halfop; // 32-bit W variants.
  logic                  jump_en;
  logic                  load_en;
  idu_ctrl_pkg::ld_op_t  load_op;
  logic                  store_en;
  idu_ctrl_pkg::st_len_t store_len;
  logic                  wb_en;
  idu_ctrl_pkg::wb_sel_t wb_sel;
  logic                  ebreak;
  logic                  i_type, s_type, b_type, u_type, j_type;

  modport dec (
    output branch_en, branch_op, alu_en, alu_pc_en, alu_imm_en, alu_op, alu_halfop,
    output jump_en, load_en, load_op, store_en, store_len, wb_en, wb_sel, ebreak,
    output i_type, s_type, b_type, u_type, j_type
  );

  modport stage (
    input branch_en, branch_op, alu_en, alu_pc_en, alu_imm_en, alu_op, alu_halfop,
    input jump_en, load_en, load_op, store_en, store_len, wb_en, wb_sel, ebreak,
    input i_type, s_type, b_type, u_type, j_type
  );
endinterface

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                 clk,
  input  logic                 rstn,
  input  rv_isa_pkg::reg_idx_t index_rs1,
  input  rv_isa_pkg::reg_idx_t index_rs2,
  output rv_isa_pkg::xlen_t    data_rs1,
  output rv_isa_pkg::xlen_t    data_rs2,
  input  logic                 wb_en,
  input  rv_isa_pkg::reg_idx_t index_rd,
  input  rv_isa_pkg::xlen_t    data_rd
);

  rv_isa_pkg::xlen_t gpr [32];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (wb_en && index_rd != '0) begin
      gpr[index_rd] <= data_rd; // x0 never written.
    end
  end

  // Write data forwarded to a read of the same index.
  assign data_rs1 = (index_rs1 == '0) ? '0 :
                    (wb_en && index_rd == index_rs1) ? data_rd : gpr[index_rs1];
  assign data_rs2 = (index_rs2 == '0) ? '0 :
                    (wb_en && index_rd == index_rs2) ? data_rd : gpr[index_rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rstn) gpr[0] == '0)
    else $error("regfile: x0 holds a nonzero value");

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder (
  input rv_isa_pkg::instr_t instr,
  decode_ctrl_if.dec        ctrl
);

  rv_isa_pkg::opc_t    opc;
  rv_isa_pkg::funct3_t f3;
  rv_isa_pkg::funct7_t f7;
  logic                f7_ok;
  logic                legal;

  function automatic idu_ctrl_pkg::alu_op_t alu_op_of(input rv_isa_pkg::funct3_t f,
                                                      input logic alt);
    case (f)
      3'd0:    return alt ? idu_ctrl_pkg::ALU_SUB : idu_ctrl_pkg::ALU_ADD;
      3'd1:    return idu_ctrl_pkg::ALU_SLL;
      3'd2:    return idu_ctrl_pkg::ALU_SLT;
      3'd3:    return idu_ctrl_pkg::ALU_SLTU;
      3'd4:    return idu_ctrl_pkg::ALU_XOR;
      3'd5:    return alt ? idu_ctrl_pkg::ALU_SRA : idu_ctrl_pkg::ALU_SRL;
      3'd6:    return idu_ctrl_pkg::ALU_OR;
      default: return idu_ctrl_pkg::ALU_AND;
    endcase
  endfunction

  assign opc = rv_isa_pkg::opc_of(instr);
  assign f3  = rv_isa_pkg::funct3_of(instr);
  assign f7  = rv_isa_pkg::funct7_of(instr);
  // Alternate funct7 only exists for SUB and SRA.
  assign f7_ok = (f7 == rv_isa_pkg::F7_BASE) ||
                 (f7 == rv_isa_pkg::F7_ALT &&
                  (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR));

  always_comb begin
    case (opc)
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_JAL: legal = 1'b1;
      rv_isa_pkg::OPC_JALR:   legal = (f3 == 3'b000);
      rv_isa_pkg::OPC_BRANCH: legal = f3 inside {idu_ctrl_pkg::BR_BEQ, idu_ctrl_pkg::BR_BNE,
                                                 idu_ctrl_pkg::BR_BLT, idu_ctrl_pkg::BR_BGE,
                                                 idu_ctrl_pkg::BR_BLTU, idu_ctrl_pkg::BR_BGEU};
      rv_isa_pkg::OPC_LOAD:   legal = f3 inside {idu_ctrl_pkg::LD_LB, idu_ctrl_pkg::LD_LH,
                                                 idu_ctrl_pkg::LD_LW, idu_ctrl_pkg::LD_LD,
                                                 idu_ctrl_pkg::LD_LBU, idu_ctrl_pkg::LD_LHU,
                                                 idu_ctrl_pkg::LD_LWU};
      rv_isa_pkg::OPC_STORE:  legal = !f3[2];
      // Six-bit shift amount, so only instr[31:26] is funct.
      rv_isa_pkg::OPC_OPIMM:  legal = (f3 == rv_isa_pkg::F3_SLL) ? (instr[31:26] == 6'h00) :
                                      (f3 == rv_isa_pkg::F3_SR)  ?
                                      (instr[31:26] inside {6'h00, 6'h10}) : 1'b1;
      rv_isa_pkg::OPC_OPIMM32: legal = (f3 == rv_isa_pkg::F3_ADD) ||
                                       (f3 == rv_isa_pkg::F3_SLL && f7 == rv_isa_pkg::F7_BASE) ||
                                       (f3 == rv_isa_pkg::F3_SR && f7_ok);
      rv_isa_pkg::OPC_OP:     legal = f7_ok;
      rv_isa_pkg::OPC_OP32:   legal = f7_ok && f3 inside {rv_isa_pkg::F3_ADD, rv_isa_pkg::F3_SLL,
                                                          rv_isa_pkg::F3_SR};
      rv_isa_pkg::OPC_SYSTEM: legal = (instr == rv_isa_pkg::INSTR_EBREAK);
      default:                legal = 1'b0;
    endcase
  end

  always_comb begin
    ctrl.branch_en  = 1'b0;
    ctrl.branch_op  = '0;
    ctrl.alu_en     = 1'b0;
    ctrl.alu_pc_en  = 1'b0;
    ctrl.alu_imm_en = 1'b0;
    ctrl.alu_op     = idu_ctrl_pkg::ALU_ADD;
    ctrl.alu_halfop = 1'b0;
    ctrl.jump_en    = 1'b0;
    ctrl.load_en    = 1'b0;
    ctrl.load_op    = '0;
    ctrl.store_en   = 1'b0;
    ctrl.store_len  = '0;
    ctrl.wb_en      = 1'b0;
    ctrl.wb_sel     = idu_ctrl_pkg::WB_ALU;
    ctrl.ebreak     = 1'b0;
    ctrl.i_type     = 1'b0;
    ctrl.s_type     = 1'b0;
    ctrl.b_type     = 1'b0;
    ctrl.u_type     = 1'b0;
    ctrl.j_type     = 1'b0;
    if (legal) begin
      case (opc)
        rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
          ctrl.alu_en     = 1'b1;
          ctrl.alu_imm_en = 1'b1;
          ctrl.alu_pc_en  = (opc == rv_isa_pkg::OPC_AUIPC);
          ctrl.alu_op     = (opc == rv_isa_pkg::OPC_LUI) ? idu_ctrl_pkg::ALU_PASS_B
                                                         : idu_ctrl_pkg::ALU_ADD;
          ctrl.u_type     = 1'b1;
          ctrl.wb_en      = 1'b1;
        end
        rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
          ctrl.jump_en    = 1'b1;
          ctrl.alu_en     = 1'b1;
          ctrl.alu_pc_en  = 1'b1;
          ctrl.alu_imm_en = 1'b1;
          ctrl.wb_en      = 1'b1;
          ctrl.wb_sel     = idu_ctrl_pkg::WB_PC4; // Link value.
          ctrl.j_type     = (opc == rv_isa_pkg::OPC_JAL);
          ctrl.i_type     = (opc == rv_isa_pkg::OPC_JALR);
        end
        rv_isa_pkg::OPC_BRANCH: begin
          ctrl.branch_en = 1'b1;
          ctrl.branch_op = f3;
          ctrl.alu_en    = 1'b1;
          ctrl.alu_op    = idu_ctrl_pkg::ALU_SUB; // Compare rs1 with rs2.
          ctrl.b_type    = 1'b1;
        end
        rv_isa_pkg::OPC_LOAD: begin
          ctrl.load_en    = 1'b1;
          ctrl.load_op    = f3;
          ctrl.alu_en     = 1'b1;
          ctrl.alu_imm_en = 1'b1;
          ctrl.i_type     = 1'b1;
          ctrl.wb_en      = 1'b1;
          ctrl.wb_sel     = idu_ctrl_pkg::WB_LOAD;
        end
        rv_isa_pkg::OPC_STORE: begin
          ctrl.store_en   = 1'b1;
          ctrl.alu_en     = 1'b1;
          ctrl.alu_imm_en = 1'b1;
          ctrl.s_type     = 1'b1;
          case (f3[1:0])
            2'd0:    ctrl.store_len = idu_ctrl_pkg::ST_LEN_B;
            2'd1:    ctrl.store_len = idu_ctrl_pkg::ST_LEN_H;
            2'd2:    ctrl.store_len = idu_ctrl_pkg::ST_LEN_W;
            default: ctrl.store_len = idu_ctrl_pkg::ST_LEN_D;
          endcase
        end
        rv_isa_pkg::OPC_OPIMM, rv_isa_pkg::OPC_OPIMM32: begin
          ctrl.alu_en     = 1'b1;
          ctrl.alu_imm_en = 1'b1;
          ctrl.alu_op     = alu_op_of(f3, f3 == rv_isa_pkg::F3_SR && instr[30]);
          ctrl.alu_halfop = (opc == rv_isa_pkg::OPC_OPIMM32);
          ctrl.i_type     = 1'b1;
          ctrl.wb_en      = 1'b1;
        end
        rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP32: begin
          ctrl.alu_en     = 1'b1;
          ctrl.alu_op     = alu_op_of(f3, instr[30]);
          ctrl.alu_halfop = (opc == rv_isa_pkg::OPC_OP32);
          ctrl.wb_en      = 1'b1;
        end
        rv_isa_pkg::OPC_SYSTEM: ctrl.ebreak = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  rv_isa_pkg::instr_t instr,
  decode_ctrl_if.stage       ctrl,
  output rv_isa_pkg::xlen_t  imm
);

  logic sign;

  assign sign = instr[31];

  always_comb begin
    if (ctrl.i_type) begin
      imm = {{52{sign}}, instr[31:20]};
    end else if (ctrl.s_type) begin
      imm = {{52{sign}}, instr[31:25], instr[11:7]};
    end else if (ctrl.b_type) begin
      imm = {{51{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    end else if (ctrl.u_type) begin
      imm = {{32{sign}}, instr[31:12], 12'b0}; // Upper 20 bits.
    end else if (ctrl.j_type) begin
      imm = {{43{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    end else begin
      imm = '0; // R-type and unknown encodings.
    end
  end

endmodule

//--- design/idu.sv
`timescale 1ns/1ps

module idu (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    flush_nop,
  input  logic                    ld_hz_nop,
  output logic                    decoder_alu_en,
  input  rv_isa_pkg::instr_t      ifu_instr,
  input  rv_isa_pkg::xlen_t       ifu_pc,
  output rv_isa_pkg::reg_idx_t    idu_index_rs1,
  output rv_isa_pkg::reg_idx_t    idu_index_rs2,
  output rv_isa_pkg::reg_idx_t    idu_index_rd,
  output rv_isa_pkg::xlen_t       idu_pc,
  output rv_isa_pkg::xlen_t       idu_gpr_data1,
  output rv_isa_pkg::xlen_t       idu_gpr_data2,
  output rv_isa_pkg::xlen_t       idu_imm,
  output idu_ctrl_pkg::alu_op_t   idu_alu_opcode,
  output logic                    idu_alu_en,
  output logic                    idu_alu_imm_en,
  output logic                    idu_alu_pc_en,
  output logic                    idu_alu_halfop,
  output idu_ctrl_pkg::br_op_t    idu_branch_opcode,
  output logic                    idu_jump_en,
  output logic                    idu_branch_en,
  output logic                    idu_load_en,
  output idu_ctrl_pkg::ld_op_t    idu_load_opcode,
  output logic                    idu_store_en,
  output idu_ctrl_pkg::st_len_t   idu_store_len,
  output logic                    idu_wb_en,
  output idu_ctrl_pkg::wb_sel_t   idu_wb_choose,
  output logic                    idu_ebreak,
  input  rv_isa_pkg::xlen_t       mmu_wb_data,
  input  rv_isa_pkg::reg_idx_t    mmu_index_rd,
  input  logic                    mmu_wb_en
);

  rv_isa_pkg::xlen_t gpr_data1;
  rv_isa_pkg::xlen_t gpr_data2;
  rv_isa_pkg::xlen_t imm;
  logic              kill;

  decode_ctrl_if ctrl ();

  regfile u_regfile (
    .clk       (clk),
    .rstn      (rstn),
    .index_rs1 (rv_isa_pkg::rs1_of(ifu_instr)),
    .index_rs2 (rv_isa_pkg::rs2_of(ifu_instr)),
    .data_rs1  (gpr_data1),
    .data_rs2  (gpr_data2),
    .wb_en     (mmu_wb_en),
    .index_rd  (mmu_index_rd),
    .data_rd   (mmu_wb_data)
  );

  decoder u_decoder (
    .instr (ifu_instr),
    .ctrl  (ctrl.dec)
  );

  imm_gen u_imm_gen (
    .instr (ifu_instr),
    .ctrl  (ctrl.stage),
    .imm   (imm)
  );

  assign kill = flush_nop | ld_hz_nop;
  assign decoder_alu_en = ctrl.alu_en;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      idu_index_rs1     <= '0;
      idu_index_rs2     <= '0;
      idu_index_rd      <= '0;
      idu_pc            <= '0;
      idu_gpr_data1     <= '0;
      idu_gpr_data2     <= '0;
      idu_imm           <= '0;
      idu_alu_opcode    <= '0;
      idu_alu_en        <= 1'b0;
      idu_alu_imm_en    <= 1'b0;
      idu_alu_pc_en     <= 1'b0;
      idu_alu_halfop    <= 1'b0;
      idu_branch_opcode <= '0;
      idu_jump_en       <= 1'b0;
      idu_branch_en     <= 1'b0;
      idu_load_en       <= 1'b0;
      idu_load_opcode   <= '0;
      idu_store_en      <= 1'b0;
      idu_store_len     <= '0;
      idu_wb_en         <= 1'b0;
      idu_wb_choose     <= '0;
      idu_ebreak        <= 1'b0;
    end else begin
      idu_index_rs1     <= rv_isa_pkg::rs1_of(ifu_instr);
      idu_index_rs2     <= rv_isa_pkg::rs2_of(ifu_instr);
      idu_index_rd      <= rv_isa_pkg::rd_of(ifu_instr);
      idu_pc            <= ifu_pc;
      idu_gpr_data1     <= gpr_data1;
      idu_gpr_data2     <= gpr_data2;
      idu_imm           <= imm;
      idu_alu_opcode    <= ctrl.alu_op;
      idu_alu_en        <= ctrl.alu_en;
      idu_alu_imm_en    <= ctrl.alu_imm_en;
      idu_alu_pc_en     <= ctrl.alu_pc_en;
      idu_alu_halfop    <= ctrl.alu_halfop;
      idu_branch_opcode <= ctrl.branch_op;
      idu_load_opcode   <= ctrl.load_op;
      idu_store_len     <= ctrl.store_len;
      idu_wb_choose     <= ctrl.wb_sel;
      // Bubble clears only what has side effects.
      idu_jump_en       <= ctrl.jump_en & ~kill;
      idu_branch_en     <= ctrl.branch_en & ~kill;
      idu_load_en       <= ctrl.load_en & ~kill;
      idu_store_en      <= ctrl.store_en & ~kill;
      idu_wb_en         <= ctrl.wb_en & ~kill;
      idu_ebreak        <= ctrl.ebreak & ~kill;
    end
  end

  a_bubble: assert property (@(posedge clk) disable iff (!rstn)
    kill |=> !(idu_jump_en || idu_branch_en || idu_load_en ||
               idu_store_en || idu_wb_en || idu_ebreak))
    else $error("idu: side effect enable set after a kill");

endmodule

//--- bench/idu_model.svh
`ifndef IDU_MODEL_SVH
`define IDU_MODEL_SVH

// Expected control fields of one instruction.
typedef struct packed {
  logic                  alu_en;
  logic                  alu_pc_en;
  logic                  alu_imm_en;
  logic                  alu_halfop;
  idu_ctrl_pkg::alu_op_t alu_op;
  logic                  jump_en;
  logic                  branch_en;
  logic                  load_en;
  logic                  store_en;
  logic                  wb_en;
  logic                  ebreak;
  idu_ctrl_pkg::br_op_t  br_op;
  idu_ctrl_pkg::ld_op_t  ld_op;
  idu_ctrl_pkg::st_len_t st_len;
  idu_ctrl_pkg::wb_sel_t wb_sel;
} ctrl_exp_t;

logic [31:0]       rng_state = 32'd30383;
rv_isa_pkg::xlen_t shadow [32];

function automatic logic [31:0] xorshift32();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// ALU operation codes by funct3.
function automatic idu_ctrl_pkg::alu_op_t alu_code(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? 5'd1 : 5'd0; // SUB or ADD.
    3'd1:    return 5'd2;
    3'd2:    return 5'd3;
    3'd3:    return 5'd4;
    3'd4:    return 5'd5;
    3'd5:    return alt ? 5'd7 : 5'd6; // SRA or SRL.
    3'd6:    return 5'd8;
    default: return 5'd9;
  endcase
endfunction

function automatic ctrl_exp_t model_decode(input rv_isa_pkg::instr_t w);
  ctrl_exp_t  e;
  logic [2:0] f3;
  f3 = w[14:12];
  e = '0;
  case (w[6:0])
    rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
      e.alu_en     = 1'b1;
      e.alu_imm_en = 1'b1;
      e.alu_pc_en  = (w[6:0] == rv_isa_pkg::OPC_AUIPC);
      e.alu_op     = (w[6:0] == rv_isa_pkg::OPC_LUI) ? 5'd10 : 5'd0;
      e.wb_en      = 1'b1;
    end
    rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
      e.jump_en    = 1'b1;
      e.alu_en     = 1'b1;
      e.alu_pc_en  = 1'b1;
      e.alu_imm_en = 1'b1;
      e.wb_en      = 1'b1;
      e.wb_sel     = 3'd2; // Return address.
    end
    rv_isa_pkg::OPC_BRANCH: begin
      e.branch_en = 1'b1;
      e.br_op     = f3;
      e.alu_en    = 1'b1;
      e.alu_op    = 5'd1;
    end
    rv_isa_pkg::OPC_LOAD: begin
      e.load_en    = 1'b1;
      e.ld_op      = f3;
      e.alu_en     = 1'b1;
      e.alu_imm_en = 1'b1;
      e.wb_en      = 1'b1;
      e.wb_sel     = 3'd1;
    end
    rv_isa_pkg::OPC_STORE: begin
      e.store_en   = 1'b1;
      e.alu_en     = 1'b1;
      e.alu_imm_en = 1'b1;
      e.st_len     = 4'd1 << f3[1:0]; // Byte count.
    end
    rv_isa_pkg::OPC_OPIMM, rv_isa_pkg::OPC_OPIMM32: begin
      e.alu_en     = 1'b1;
      e.alu_imm_en = 1'b1;
      e.alu_op     = alu_code(f3, f3 == 3'd5 && w[30]);
      e.alu_halfop = (w[6:0] == rv_isa_pkg::OPC_OPIMM32);
      e.wb_en      = 1'b1;
    end
    rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP32: begin
      e.alu_en     = 1'b1;
      e.alu_op     = alu_code(f3, w[30]);
      e.alu_halfop = (w[6:0] == rv_isa_pkg::OPC_OP32);
      e.wb_en      = 1'b1;
    end
    rv_isa_pkg::OPC_SYSTEM: e.ebreak = (w == rv_isa_pkg::INSTR_EBREAK);
    default: ;
  endcase
  return e;
endfunction

function automatic rv_isa_pkg::xlen_t model_imm(input rv_isa_pkg::instr_t w);
  case (w[6:0])
    rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_LOAD,
    rv_isa_pkg::OPC_OPIMM, rv_isa_pkg::OPC_OPIMM32:
      return 64'($signed(w[31:20]));
    rv_isa_pkg::OPC_STORE:
      return 64'($signed({w[31:25], w[11:7]}));
    rv_isa_pkg::OPC_BRANCH:
      return 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC:
      return 64'($signed({w[31:12], 12'h000}));
    rv_isa_pkg::OPC_JAL:
      return 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    default:
      return '0;
  endcase
endfunction

function automatic rv_isa_pkg::xlen_t shadow_read(input rv_isa_pkg::reg_idx_t idx,
                                                  input logic we,
                                                  input rv_isa_pkg::reg_idx_t widx,
                                                  input rv_isa_pkg::xlen_t wdata);
  if (idx == 5'd0) begin
    return '0;
  end
  if (we && widx == idx) begin
    return wdata; // Same-cycle write forwarded.
  end
  return shadow[idx];
endfunction

function automatic void shadow_write(input logic we, input rv_isa_pkg::reg_idx_t widx,
                                     input rv_isa_pkg::xlen_t wdata);
  if (we && widx != 5'd0) begin
    shadow[widx] = wdata;
  end
endfunction

`endif

//--- bench/idu_tb.sv
`timescale 1ns/1ps

module idu_tb;

  `include "idu_model.svh"

  localparam int RESET_CYCLES    = 10;
  localparam int CYCLES_PER_TEST = 400;
  localparam int TIMEOUT_CYCLES  = 5 * CYCLES_PER_TEST + 500; // All tests plus margin.

  localparam int G_JALR    = 3;
  localparam int G_BRANCH  = 4;
  localparam int G_LOAD    = 5;
  localparam int G_STORE   = 6;
  localparam int G_EBREAK  = 7;
  localparam int G_OPIMM   = 8;
  localparam int G_OPIMM32 = 9;
  localparam int G_OP      = 10;
  localparam int G_OP32    = 11;
  localparam int G_GARBAGE = 12;

  localparam int MODE_ALU    = 0;
  localparam int MODE_CTRL   = 1;
  localparam int MODE_BYPASS = 2;
  localparam int MODE_KILL   = 3;

  logic                  clk = 1'b0;
  logic                  rstn;
  logic                  flush_nop;
  logic                  ld_hz_nop;
  logic                  decoder_alu_en;
  rv_isa_pkg::instr_t    ifu_instr;
  rv_isa_pkg::xlen_t     ifu_pc;
  rv_isa_pkg::reg_idx_t  idu_index_rs1;
  rv_isa_pkg::reg_idx_t  idu_index_rs2;
  rv_isa_pkg::reg_idx_t  idu_index_rd;
  rv_isa_pkg::xlen_t     idu_pc;
  rv_isa_pkg::xlen_t     idu_gpr_data1;
  rv_isa_pkg::xlen_t     idu_gpr_data2;
  rv_isa_pkg::xlen_t     idu_imm;
  idu_ctrl_pkg::alu_op_t idu_alu_opcode;
  logic                  idu_alu_en;
  logic                  idu_alu_imm_en;
  logic                  idu_alu_pc_en;
  logic                  idu_alu_halfop;
  idu_ctrl_pkg::br_op_t  idu_branch_opcode;
  logic                  idu_jump_en;
  logic                  idu_branch_en;
  logic                  idu_load_en;
  idu_ctrl_pkg::ld_op_t  idu_load_opcode;
  logic                  idu_store_en;
  idu_ctrl_pkg::st_len_t idu_store_len;
  logic                  idu_wb_en;
  idu_ctrl_pkg::wb_sel_t idu_wb_choose;
  logic                  idu_ebreak;
  rv_isa_pkg::xlen_t     mmu_wb_data;
  rv_isa_pkg::reg_idx_t  mmu_index_rd;
  logic                  mmu_wb_en;

  // Expected values for the instruction now in the stage register.
  ctrl_exp_t            exp_ctrl;
  rv_isa_pkg::reg_idx_t exp_rs1;
  rv_isa_pkg::reg_idx_t exp_rs2;
  rv_isa_pkg::reg_idx_t exp_rd;
  rv_isa_pkg::xlen_t    exp_pc;
  rv_isa_pkg::xlen_t    exp_imm;
  rv_isa_pkg::xlen_t    exp_d1;
  rv_isa_pkg::xlen_t    exp_d2;
  logic                 pending;

  string test_name;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;
  int    bubbles;
  int    cycle_count;

  idu idu_i (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_val(input string field, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, field, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_outputs();
    check_val("idu_index_rs1", exp_rs1, idu_index_rs1);
    check_val("idu_index_rs2", exp_rs2, idu_index_rs2);
    check_val("idu_index_rd", exp_rd, idu_index_rd);
    check_val("idu_pc", exp_pc, idu_pc);
    check_val("idu_gpr_data1", exp_d1, idu_gpr_data1);
    check_val("idu_gpr_data2", exp_d2, idu_gpr_data2);
    check_val("idu_imm", exp_imm, idu_imm);
    check_val("idu_alu_opcode", exp_ctrl.alu_op, idu_alu_opcode);
    check_val("idu_alu_en", exp_ctrl.alu_en, idu_alu_en);
    check_val("idu_alu_imm_en", exp_ctrl.alu_imm_en, idu_alu_imm_en);
    check_val("idu_alu_pc_en", exp_ctrl.alu_pc_en, idu_alu_pc_en);
    check_val("idu_alu_halfop", exp_ctrl.alu_halfop, idu_alu_halfop);
    check_val("idu_branch_opcode", exp_ctrl.br_op, idu_branch_opcode);
    check_val("idu_jump_en", exp_ctrl.jump_en, idu_jump_en);
    check_val("idu_branch_en", exp_ctrl.branch_en, idu_branch_en);
    check_val("idu_load_en", exp_ctrl.load_en, idu_load_en);
    check_val("idu_load_opcode", exp_ctrl.ld_op, idu_load_opcode);
    check_val("idu_store_en", exp_ctrl.store_en, idu_store_en);
    check_val("idu_store_len", exp_ctrl.st_len, idu_store_len);
    check_val("idu_wb_en", exp_ctrl.wb_en, idu_wb_en);
    check_val("idu_wb_choose", exp_ctrl.wb_sel, idu_wb_choose);
    check_val("idu_ebreak", exp_ctrl.ebreak, idu_ebreak);
  endtask

  function automatic int pick_group(input int mode);
    logic [31:0] r;
    r = xorshift32();
    if (mode == MODE_ALU) begin
      return G_OPIMM + int'(r % 32'd4);
    end
    if (r[31:24] < 8'd13) begin
      return G_GARBAGE; // About 5%.
    end
    if (mode == MODE_CTRL) begin
      return int'(r % 32'd8);
    end
    return int'(r % 32'd12);
  endfunction

  // Random fields, fixed up so that every template word is a legal encoding.
  function automatic rv_isa_pkg::instr_t make_instr(input int grp, input logic narrow);
    rv_isa_pkg::instr_t w;
    logic [2:0]         f3;
    w = xorshift32();
    f3 = w[14:12];
    if (grp == G_OPIMM32 || grp == G_OP32) begin
      f3 = (f3[1:0] == 2'd0) ? 3'd0 : (f3[1:0] == 2'd1) ? 3'd1 : 3'd5;
    end
    case (grp)
      0:         w[6:0] = rv_isa_pkg::OPC_LUI;
      1:         w[6:0] = rv_isa_pkg::OPC_AUIPC;
      2:         w[6:0] = rv_isa_pkg::OPC_JAL;
      G_JALR: begin
        w[6:0] = rv_isa_pkg::OPC_JALR;
        f3 = 3'd0;
      end
      G_BRANCH: begin
        w[6:0] = rv_isa_pkg::OPC_BRANCH;
        f3[2] = f3[2] | f3[1]; // No funct3 2 or 3.
      end
      G_LOAD: begin
        w[6:0] = rv_isa_pkg::OPC_LOAD;
        f3 = (f3 == 3'd7) ? 3'd3 : f3;
      end
      G_STORE: begin
        w[6:0] = rv_isa_pkg::OPC_STORE;
        f3[2] = 1'b0;
      end
      G_OPIMM: begin
        w[6:0] = rv_isa_pkg::OPC_OPIMM;
        if (f3 == 3'd1) begin
          w[31:26] = 6'h00;
        end else if (f3 == 3'd5) begin
          w[31:26] = {1'b0, w[30], 4'h0};
        end
      end
      G_OPIMM32: begin
        w[6:0] = rv_isa_pkg::OPC_OPIMM32;
        if (f3 != 3'd0) begin
          w[31:25] = {1'b0, w[30] & f3[2], 5'h00};
        end
      end
      G_OP: begin
        w[6:0] = rv_isa_pkg::OPC_OP;
        w[31:25] = {1'b0, w[30] & (f3 == 3'd0 || f3 == 3'd5), 5'h00};
      end
      G_OP32: begin
        w[6:0] = rv_isa_pkg::OPC_OP32;
        w[31:25] = {1'b0, w[30] & (f3 != 3'd1), 5'h00};
      end
      G_EBREAK:  w = rv_isa_pkg::INSTR_EBREAK;
      default:   w[1:0] = 2'b00; // Outside the 32-bit opcode space.
    endcase
    if (grp != G_EBREAK) begin
      w[14:12] = f3;
      if (narrow) begin
        w[11:9]  = 3'b000; // Indices 0 to 3 collide often.
        w[19:17] = 3'b000;
        w[24:22] = 3'b000;
      end
    end
    return w;
  endfunction

  task automatic step(input int mode);
    rv_isa_pkg::instr_t w;
    logic [31:0]        r;
    logic               kill;
    ctrl_exp_t          e;
    @(posedge clk);
    #1;
    if (pending) begin
      compare_outputs();
    end
    r = xorshift32();
    w = make_instr(pick_group(mode), mode == MODE_BYPASS);
    ifu_instr = w;
    ifu_pc = {xorshift32(), xorshift32()};
    flush_nop = r[7:0] < 8'd26;
    ld_hz_nop = r[15:8] < 8'd26;
    mmu_wb_en = r[16];
    mmu_index_rd = (mode == MODE_BYPASS) ? {3'b000, r[18:17]} : r[21:17];
    mmu_wb_data = {xorshift32(), xorshift32()};
    e = model_decode(w);
    kill = flush_nop | ld_hz_nop;
    if (kill && (e.jump_en | e.branch_en | e.load_en | e.store_en | e.wb_en | e.ebreak)) begin
      bubbles++;
    end
    if (kill) begin
      e.jump_en = 1'b0;
      e.branch_en = 1'b0;
      e.load_en = 1'b0;
      e.store_en = 1'b0;
      e.wb_en = 1'b0;
      e.ebreak = 1'b0;
    end
    exp_ctrl = e;
    exp_rs1 = w[19:15];
    exp_rs2 = w[24:20];
    exp_rd = w[11:7];
    exp_pc = ifu_pc;
    exp_imm = model_imm(w);
    exp_d1 = shadow_read(w[19:15], mmu_wb_en, mmu_index_rd, mmu_wb_data);
    exp_d2 = shadow_read(w[24:20], mmu_wb_en, mmu_index_rd, mmu_wb_data);
    pending = 1'b1;
    shadow_write(mmu_wb_en, mmu_index_rd, mmu_wb_data);
    #1;
    check_val("decoder_alu_en", exp_ctrl.alu_en, decoder_alu_en); // Alu enable is never masked.
  endtask

  task automatic report_test();
    $display("%-16s %s, %0d errors", test_name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
  endtask

  task automatic run_test(input string name, input int mode);
    test_name = name;
    test_errors = 0;
    bubbles = 0;
    repeat (CYCLES_PER_TEST) step(mode);
    @(posedge clk);
    #1;
    compare_outputs(); // Last instruction of the test.
    pending = 1'b0;
    ifu_instr = '0;
    flush_nop = 1'b0;
    ld_hz_nop = 1'b0;
    mmu_wb_en = 1'b0;
    if (mode == MODE_KILL && bubbles == 0) begin
      $display("%s: no killed instruction with side effects was driven", name);
      test_errors++;
    end
    report_test();
  endtask

  initial begin
    rstn = 1'b0;
    flush_nop = 1'b0;
    ld_hz_nop = 1'b0;
    ifu_instr = '0;
    ifu_pc = '0;
    mmu_wb_data = '0;
    mmu_index_rd = '0;
    mmu_wb_en = 1'b0;
    pending = 1'b0;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    @(posedge clk);
    #1;
    // Live inputs during reset must not reach the outputs or the file.
    ifu_instr = make_instr(0, 1'b0);
    ifu_pc = {xorshift32(), xorshift32()};
    mmu_wb_en = 1'b1;
    mmu_index_rd = 5'd1;
    mmu_wb_data = {xorshift32(), xorshift32()};
    repeat (RESET_CYCLES - 1) @(posedge clk);
    #1;
    test_name = "reset_state";
    test_errors = 0;
    exp_ctrl = '0;
    exp_rs1 = '0;
    exp_rs2 = '0;
    exp_rd = '0;
    exp_pc = '0;
    exp_imm = '0;
    exp_d1 = '0;
    exp_d2 = '0;
    compare_outputs();
    report_test();
    rstn = 1'b1;
    mmu_wb_en = 1'b0;
    ifu_instr = '0;

    run_test("alu_decode", MODE_ALU);
    run_test("control_flow_mem", MODE_CTRL);
    run_test("regfile_bypass", MODE_BYPASS);
    run_test("bubble_kill", MODE_KILL);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+bench
design/rv_isa_pkg.sv
design/idu_ctrl_pkg.sv
design/decode_ctrl_if.sv
design/regfile.sv
design/decoder.sv
design/imm_gen.sv
design/idu.sv
bench/idu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module idu_tb -f src.f -o idu_sim \
  && ./obj_dir/idu_sim | tee sim.log \
  || { echo "Build or simulation failed"; exit 1; }

grep -qx "Finished with no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
